// ==== dual_clock_fifo.f ====
fifo_pkg.sv
dual_port_ram.sv
ptr_sync.sv
fifo_write_ctrl.sv
fifo_read_ctrl.sv
dual_clock_fifo.sv
dual_clock_fifo_asserts.sv
tb_dual_clock_fifo.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log for a failure
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_dual_clock_fifo -f dual_clock_fifo.f -o sim_fifo

./obj_dir/sim_fifo | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

// ==== tb_dual_clock_fifo.sv ====
/* steps through a table of FIFO operations and checks data and flags against a queue model
   rd_clk runs at 56 ns against the 40 ns clk so the phase between them drifts */
module tb_dual_clock_fifo;
    timeunit 1ns;
    timeprecision 100ps;
    import fifo_pkg::*;

    typedef enum {OP_RESET_FLAGS, OP_WRITE, OP_READ, OP_WAIT_EMPTY_FALL, OP_RANDOM,
                  OP_MID_RESET} op_e;

    typedef struct {
        string name;
        op_e   op;
        int    count;    // words, steps or extra cycles, 0 on a read means drain all
    } step_t;

    logic              clk;
    logic              reset;
    logic              write;
    logic [DATA_W-1:0] write_data;
    logic              full;
    logic              hi_thrsh;
    logic              rd_clk;
    logic              read;
    logic [DATA_W-1:0] read_data;
    logic              empty;
    logic              lo_thrsh;

    step_t             steps[$];
    logic [DATA_W-1:0] model[$];    // words written and not yet read back
    logic [31:0]       rnd_state = 32'h6397;
    string             cur_name = "startup";
    int                cycles = 0;
    int                cycle_limit = 200;
    int                errors = 0;
    int                checks = 0;

    dual_clock_fifo dut (
        .clk        (clk),
        .reset      (reset),
        .write      (write),
        .write_data (write_data),
        .full       (full),
        .hi_thrsh   (hi_thrsh),
        .rd_clk     (rd_clk),
        .read       (read),
        .read_data  (read_data),
        .empty      (empty),
        .lo_thrsh   (lo_thrsh)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rd_clk = 1'b0;
        forever #28 rd_clk = ~rd_clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: test %s did not finish within %0d clk cycles",
                     cur_name, cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rnd_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rnd_state = x;
        return x;
    endfunction

    task automatic add_step(input string name, input op_e op, input int count);
        step_t s;
        s.name = name;
        s.op = op;
        s.count = count;
        steps.push_back(s);
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        assert (exp == act) else begin
            $display("ERROR %s: %s expected %0b, actual %0b", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_data(input string what, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        checks++;
        assert (exp == act) else begin
            $display("ERROR %s: %s expected %02h, actual %02h", cur_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_fault(input string msg);
        $display("ERROR %s: %s", cur_name, msg);
        errors++;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic check_reset_flags(input int n);
        repeat (n) @(posedge rd_clk);
        @(negedge rd_clk);
        check_flag("empty", 1'b1, empty);
        check_flag("lo_thrsh", 1'b1, lo_thrsh);
        check_flag("full", 1'b0, full);
        check_flag("hi_thrsh", 1'b0, hi_thrsh);
    endtask

    // waits for the last written word to reach the read side
    task automatic settle_read_side();
        while (empty) @(negedge rd_clk);
        repeat (4) @(negedge rd_clk);
    endtask

    task automatic write_burst(input int n);
        logic [31:0] rnd;
        int          base;
        int          i;
        repeat (6) @(posedge clk);    // rd_ptr_wr catches up with earlier reads
        base = model.size();
        rnd = next_random();
        write <= 1'b1;
        write_data <= rnd[31 -: DATA_W];
        model.push_back(rnd[31 -: DATA_W]);
        for (i = 0; i < n; i++) begin
            @(posedge clk);    // word i stored
            if (i < n - 1) begin
                rnd = next_random();
                write_data <= rnd[31 -: DATA_W];
                model.push_back(rnd[31 -: DATA_W]);
            end else begin
                write <= 1'b0;
            end
            @(negedge clk);
            check_flag("full", (base + i + 1) == DEPTH, full);
            check_flag("hi_thrsh", (base + i + 1) > int'(HI_THRSH), hi_thrsh);
        end
    endtask

    task automatic read_burst(input int n);
        logic [DATA_W-1:0] exp;
        int                total;
        int                i;
        total = (n == 0) ? model.size() : n;
        if (total > 0) begin
            settle_read_side();
            @(posedge rd_clk);
            read <= 1'b1;
            for (i = 0; i < total; i++) begin
                @(posedge rd_clk);    // read_data loads here
                if (i == total - 1) begin
                    read <= 1'b0;
                end
                @(negedge rd_clk);
                exp = model.pop_front();
                check_data("read_data", exp, read_data);
                check_flag("empty", model.size() == 0, empty);
                check_flag("lo_thrsh", model.size() < int'(LO_THRSH), lo_thrsh);
            end
        end
    endtask

    task automatic wait_empty_fall(input int n);
        while (empty) @(negedge rd_clk);
        repeat (n) @(negedge rd_clk);
        check_flag("empty", model.size() == 0, empty);
        check_flag("lo_thrsh", model.size() < int'(LO_THRSH), lo_thrsh);
    endtask

    task automatic random_writer(input int n);
        logic [31:0] rnd;
        int          i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            rnd = next_random();
            if (!full && rnd[1:0] != 2'b00) begin
                assert (model.size() < DEPTH)
                    else report_fault("full stayed low with 16 words already stored");
                @(posedge clk);
                write <= 1'b1;
                write_data <= rnd[31 -: DATA_W];
                model.push_back(rnd[31 -: DATA_W]);
                @(posedge clk);
                write <= 1'b0;
            end
        end
    endtask

    task automatic random_reader(input int n);
        logic [31:0]       rnd;
        logic [DATA_W-1:0] exp;
        int                i;
        for (i = 0; i < n; i++) begin
            @(negedge rd_clk);
            rnd = next_random();
            if (!empty && rnd[2]) begin
                assert (model.size() > 0)
                    else report_fault("empty was low with no word left to read");
                @(posedge rd_clk);
                read <= 1'b1;
                @(posedge rd_clk);
                read <= 1'b0;
                @(negedge rd_clk);
                exp = model.pop_front();
                check_data("read_data", exp, read_data);
            end
        end
    endtask

    initial begin
        int k;
        int errors_before;
        reset = 1'b1;
        write = 1'b0;
        write_data = '0;
        read = 1'b0;

        add_step("reset_flags", OP_RESET_FLAGS, 3);
        add_step("fill_to_full", OP_WRITE, 16);
        add_step("drain_in_order", OP_READ, 16);
        add_step("lo_write_six", OP_WRITE, 6);
        add_step("lo_wait_sync", OP_WAIT_EMPTY_FALL, 4);
        add_step("lo_read_three", OP_READ, 3);
        add_step("random_interleave", OP_RANDOM, 200);
        add_step("drain_random", OP_READ, 0);
        add_step("refill_five", OP_WRITE, 5);
        add_step("mid_run_reset", OP_MID_RESET, 1);

        cycle_limit = 200;
        for (k = 0; k < steps.size(); k++) begin
            cycle_limit = cycle_limit + steps[k].count * 8;
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        for (k = 0; k < steps.size(); k++) begin
            cur_name = steps[k].name;
            errors_before = errors;
            case (steps[k].op)
                OP_RESET_FLAGS:     check_reset_flags(steps[k].count);
                OP_WRITE:           write_burst(steps[k].count);
                OP_READ:            read_burst(steps[k].count);
                OP_WAIT_EMPTY_FALL: wait_empty_fall(steps[k].count);
                OP_RANDOM: begin
                    fork
                        random_writer(steps[k].count);
                        random_reader(steps[k].count);
                    join
                end
                OP_MID_RESET: begin
                    apply_reset();
                    model.delete();
                    check_reset_flags(3);
                    write_burst(1);    // one fresh word through the cleared FIFO
                    read_burst(1);
                end
                default:            report_fault("unknown table operation");
            endcase
            $display("test %-18s %s", cur_name, (errors == errors_before) ? "ok" : "failed");
        end

        $display("tests %0d, checks %0d, errors %0d", steps.size(), checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== dual_clock_fifo_asserts.sv ====
/* strobe misuse and flag sanity for dual_clock_fifo, bound to every instance
   the read-side checks are off while the synchronized read reset is high */
module dual_clock_fifo_asserts (
    input logic                        clk,
    input logic                        reset,
    input logic                        write,
    input logic                        full,
    input logic                        rd_clk,
    input logic                        rd_reset,
    input logic                        read,
    input logic                        empty,
    input logic [fifo_pkg::PTR_W-1:0]  wr_ptr,
    input logic [fifo_pkg::PTR_W-1:0]  rd_ptr,
    input logic [fifo_pkg::PTR_W-1:0]  wr_ptr_rd,
    input logic [fifo_pkg::PTR_W-1:0]  rd_ptr_wr
);
    timeunit 1ns;
    timeprecision 100ps;
    import fifo_pkg::*;

    no_write_when_full: assert property (@(posedge clk) disable iff (reset) write |-> !full)
        else $error("write strobe seen while full");

    no_read_when_empty: assert property (@(posedge rd_clk) disable iff (rd_reset) read |-> !empty)
        else $error("read strobe seen while empty");

    // each side's own fill never passes DEPTH
    wr_view_consistent: assert property (@(posedge clk) disable iff (reset)
        (wr_ptr - rd_ptr_wr) <= PTR_W'(DEPTH))
        else $error("write side sees more than DEPTH words stored");

    rd_view_consistent: assert property (@(posedge rd_clk) disable iff (rd_reset)
        (wr_ptr_rd - rd_ptr) <= PTR_W'(DEPTH))
        else $error("read side sees more than DEPTH words stored");

    empty_after_rd_reset: assert property (@(posedge rd_clk) rd_reset |=> empty)
        else $error("empty not high after the read reset");

endmodule

bind dual_clock_fifo dual_clock_fifo_asserts asserts (
    .clk       (clk),
    .reset     (reset),
    .write     (write),
    .full      (full),
    .rd_clk    (rd_clk),
    .rd_reset  (rd_reset),
    .read      (read),
    .empty     (empty),
    .wr_ptr    (wr_ptr),
    .rd_ptr    (rd_ptr),
    .wr_ptr_rd (wr_ptr_rd),
    .rd_ptr_wr (rd_ptr_wr)
);

// ==== dual_clock_fifo.sv ====
/* write side on clk with the synchronous reset, read side on rd_clk
   flags are the only back-pressure; the user keeps write and read off when full or empty */
module dual_clock_fifo (
    // write side
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         write,
    input  logic [fifo_pkg::DATA_W-1:0]  write_data,
    output logic                         full,
    output logic                         hi_thrsh,
    // read side
    input  logic                         rd_clk,
    input  logic                         read,
    output logic [fifo_pkg::DATA_W-1:0]  read_data,
    output logic                         empty,
    output logic                         lo_thrsh
);
    import fifo_pkg::*;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_rd;    // wr_ptr as seen in rd_clk
    logic [PTR_W-1:0] rd_ptr_wr;    // rd_ptr as seen in clk
    logic             rd_reset;

    dual_port_ram ram (
        .clk        (clk),
        .write      (write),
        .wr_addr    (wr_ptr[ADDR_W-1:0]),
        .write_data (write_data),
        .rd_clk     (rd_clk),
        .read       (read),
        .rd_addr    (rd_ptr[ADDR_W-1:0]),
        .read_data  (read_data)
    );

    fifo_write_ctrl wr_ctrl (
        .clk       (clk),
        .reset     (reset),
        .write     (write),
        .rd_ptr_wr (rd_ptr_wr),
        .wr_ptr    (wr_ptr),
        .full      (full),
        .hi_thrsh  (hi_thrsh)
    );

    fifo_read_ctrl rd_ctrl (
        .rd_clk    (rd_clk),
        .reset     (reset),
        .read      (read),
        .wr_ptr_rd (wr_ptr_rd),
        .rd_ptr    (rd_ptr),
        .rd_reset  (rd_reset),
        .empty     (empty),
        .lo_thrsh  (lo_thrsh)
    );

    // clk to rd_clk
    ptr_sync wr_ptr_sync (
        .src_clk   (clk),
        .src_reset (reset),
        .src_ptr   (wr_ptr),
        .dst_clk   (rd_clk),
        .dst_reset (rd_reset),
        .dst_ptr   (wr_ptr_rd)
    );

    // rd_clk to clk
    ptr_sync rd_ptr_sync (
        .src_clk   (rd_clk),
        .src_reset (rd_reset),
        .src_ptr   (rd_ptr),
        .dst_clk   (clk),
        .dst_reset (reset),
        .dst_ptr   (rd_ptr_wr)
    );

endmodule

// ==== fifo_read_ctrl.sv ====
/* no underflow guard, read must stay low while empty is high
   the read side leaves reset two rd_clk edges after reset falls */
module fifo_read_ctrl (
    input  logic                        rd_clk,
    input  logic                        reset,
    input  logic                        read,
    input  logic [fifo_pkg::PTR_W-1:0]  wr_ptr_rd,
    output logic [fifo_pkg::PTR_W-1:0]  rd_ptr,
    output logic                        rd_reset,
    output logic                        empty,
    output logic                        lo_thrsh
);
    import fifo_pkg::*;

    logic [1:0]       rst_pipe;    // reset synchronizer, [1] is the synced copy
    logic [PTR_W-1:0] fill;

    always_ff @(posedge rd_clk) begin
        rst_pipe <= {rst_pipe[0], reset};
    end

    assign rd_reset = rst_pipe[1];

    always_ff @(posedge rd_clk) begin
        if (rd_reset) begin
            rd_ptr <= '0;
        end else if (read) begin
            rd_ptr <= rd_ptr + PTR_W'(1);
        end
    end

    // the write pointer arrives late here, so empty may stay high a little too long
    assign empty = (wr_ptr_rd == rd_ptr);

    assign fill     = wr_ptr_rd - rd_ptr;
    assign lo_thrsh = (fill < LO_THRSH);

endmodule

// ==== fifo_write_ctrl.sv ====
/* no overflow guard, write must stay low while full is high
   full and hi_thrsh see the read side late, so they only err towards full */
module fifo_write_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        write,
    input  logic [fifo_pkg::PTR_W-1:0]  rd_ptr_wr,
    output logic [fifo_pkg::PTR_W-1:0]  wr_ptr,
    output logic                        full,
    output logic                        hi_thrsh
);
    import fifo_pkg::*;

    logic [PTR_W-1:0] fill;
    logic [PTR_W-1:0] full_ptr;    // write pointer value that means full

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (write) begin
            wr_ptr <= wr_ptr + PTR_W'(1);
        end
    end

    // full when one lap ahead: wrap bit differs, address bits match
    assign full_ptr = {~rd_ptr_wr[PTR_W-1], rd_ptr_wr[ADDR_W-1:0]};
    assign full     = (wr_ptr == full_ptr);

    assign fill     = wr_ptr - rd_ptr_wr;    // modulo 2*DEPTH, reaches DEPTH when full
    assign hi_thrsh = (fill > HI_THRSH);

endmodule

// ==== ptr_sync.sv ====
/* src_ptr may step by at most one per src_clk edge, so only one gray bit moves at a time
   dst_ptr lags src_ptr by one src_clk edge plus two or three dst_clk edges */
module ptr_sync (
    input  logic                        src_clk,
    input  logic                        src_reset,
    input  logic [fifo_pkg::PTR_W-1:0]  src_ptr,
    input  logic                        dst_clk,
    input  logic                        dst_reset,
    output logic [fifo_pkg::PTR_W-1:0]  dst_ptr
);
    import fifo_pkg::*;

    logic [PTR_W-1:0] src_gray;    // registered so no combinational glitch crosses
    logic [PTR_W-1:0] dst_meta;
    logic [PTR_W-1:0] dst_gray;

    function automatic logic [PTR_W-1:0] gray_to_bin(input logic [PTR_W-1:0] gray);
        logic [PTR_W-1:0] bin;
        bin[PTR_W-1] = gray[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    always_ff @(posedge src_clk) begin
        if (src_reset) begin
            src_gray <= '0;
        end else begin
            src_gray <= src_ptr ^ (src_ptr >> 1);
        end
    end

    // two-flop synchronizer in the destination domain
    always_ff @(posedge dst_clk) begin
        if (dst_reset) begin
            dst_meta <= '0;
            dst_gray <= '0;
        end else begin
            dst_meta <= src_gray;
            dst_gray <= dst_meta;
        end
    end

    assign dst_ptr = gray_to_bin(dst_gray);

endmodule

// ==== dual_port_ram.sv ====
/* simple dual-port memory, no reset; contents are undefined until written
   read_data is registered and only loads when read is high */
module dual_port_ram (
    input  logic                         clk,
    input  logic                         write,
    input  logic [fifo_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [fifo_pkg::DATA_W-1:0]  write_data,
    input  logic                         rd_clk,
    input  logic                         read,
    input  logic [fifo_pkg::ADDR_W-1:0]  rd_addr,
    output logic [fifo_pkg::DATA_W-1:0]  read_data
);
    import fifo_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];

    // write port, clk domain
    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_addr] <= write_data;
        end
    end

    // read port holds its word until the next read
    always_ff @(posedge rd_clk) begin
        if (read) begin
            read_data <= mem[rd_addr];
        end
    end

endmodule

// ==== fifo_pkg.sv ====
/* sizes and thresholds of the dual-clock FIFO; the RTL is built for these values only
   DEPTH must stay a power of two so the pointer wrap bit works */
package fifo_pkg;

    // data word
    localparam int unsigned DATA_W = 8;

    // storage
    localparam int unsigned DEPTH  = 16;
    localparam int unsigned ADDR_W = $clog2(DEPTH);
    localparam int unsigned PTR_W  = ADDR_W + 1;    // extra wrap bit tells full from empty

    // fill levels, compared against the full pointer difference so a full FIFO reads as DEPTH
    localparam logic [PTR_W-1:0] LO_THRSH = PTR_W'(4);     // read side, flag below this
    localparam logic [PTR_W-1:0] HI_THRSH = PTR_W'(12);    // write side, flag above this

endpackage
